// File: hw/dcache_pkg.sv
package dcache_pkg;

    localparam int DEF_INDEX_BITS  = 6;
    localparam int DEF_OFFSET_BITS = 6; // 64-byte lines, 16 words

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  wmask_t;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } cpu_op_e;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        RESPOND
    } ctrl_state_e;

    typedef struct packed {
        cpu_op_e op;
        addr_t   addr;
        wmask_t  wmask;
        word_t   wdata;
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;
        logic  hit;
    } cpu_rsp_t;

    typedef struct packed {
        addr_t      addr; // line aligned
        logic [7:0] len;  // beats minus one
    } mem_ar_t;

    typedef struct packed {
        addr_t      addr;
        logic [7:0] len;
    } mem_aw_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } mem_r_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } mem_w_t;

endpackage

// File: hw/dcache_tag_array.sv
`timescale 1ns/1ps

module dcache_tag_array #(
    parameter int INDEX_BITS  = dcache_pkg::DEF_INDEX_BITS,
    parameter int OFFSET_BITS = dcache_pkg::DEF_OFFSET_BITS
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  dcache_pkg::addr_t                     addr,
    input  logic                                  lookup_en,
    input  logic                                  tag_fill,
    input  logic                                  mark_access,
    input  logic                                  is_write,
    output logic                                  hit,
    output logic                                  hit_way,
    output logic                                  victim_way,
    output logic                                  victim_dirty,
    output logic [31-INDEX_BITS-OFFSET_BITS:0]    victim_tag
);

    localparam int TAG_BITS = 32 - INDEX_BITS - OFFSET_BITS;
    localparam int SETS     = 1 << INDEX_BITS;

    logic [TAG_BITS-1:0] tag_mem [2][SETS];
    logic [TAG_BITS-1:0] tag_rd [2];
    logic [1:0]          valid [SETS];
    logic [1:0]          dirty [SETS];
    logic [SETS-1:0]     lru; // points at the way to evict
    logic [1:0]          way_hit;

    wire [INDEX_BITS-1:0] idx = addr[OFFSET_BITS +: INDEX_BITS];
    wire [TAG_BITS-1:0]   tag = addr[31 -: TAG_BITS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (tag_fill && victim_way == 1'(w)) begin
                tag_mem[w][idx] <= tag;
                tag_rd[w]       <= tag; // new tag visible to the next lookup
            end else if (lookup_en) begin
                tag_rd[w] <= tag_mem[w][idx];
            end
        end
    end

    assign way_hit[0] = valid[idx][0] && tag_rd[0] == tag;
    assign way_hit[1] = valid[idx][1] && tag_rd[1] == tag;
    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];

    assign victim_way   = lru[idx];
    assign victim_dirty = valid[idx][victim_way] && dirty[idx][victim_way];
    assign victim_tag   = tag_rd[victim_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '{default: '0};
            dirty <= '{default: '0};
            lru   <= '0;
        end else begin
            if (tag_fill) begin
                valid[idx][victim_way] <= 1'b1;
                dirty[idx][victim_way] <= 1'b0;
            end
            if (mark_access) begin
                lru[idx] <= ~hit_way;
                if (is_write)
                    dirty[idx][hit_way] <= 1'b1;
            end
        end
    end

endmodule

// File: hw/dcache_data_array.sv
`timescale 1ns/1ps

module dcache_data_array #(
    parameter int INDEX_BITS  = dcache_pkg::DEF_INDEX_BITS,
    parameter int OFFSET_BITS = dcache_pkg::DEF_OFFSET_BITS
) (
    input  logic                     clk,
    input  dcache_pkg::addr_t        addr,
    input  logic [OFFSET_BITS-3:0]   rd_addr,
    input  logic                     rd_sel_wb,
    input  logic                     wr_way,
    input  logic                     store_en,
    input  dcache_pkg::wmask_t       wmask,
    input  dcache_pkg::word_t        wdata,
    input  logic                     refill_beat_valid,
    input  logic [OFFSET_BITS-3:0]   refill_word,
    input  dcache_pkg::word_t        refill_data,
    input  logic                     rd_way,
    output dcache_pkg::word_t        rdata
);

    localparam int WORD_BITS = OFFSET_BITS - 2;
    localparam int DEPTH     = 1 << (INDEX_BITS + WORD_BITS);

    dcache_pkg::word_t mem [2][DEPTH];
    dcache_pkg::word_t rd_q [2];

    wire [INDEX_BITS-1:0] idx = addr[OFFSET_BITS +: INDEX_BITS];
    wire [WORD_BITS-1:0]  req_word = addr[OFFSET_BITS-1:2];
    wire [WORD_BITS-1:0]  rd_word = rd_sel_wb ? rd_addr : req_word; // writeback reads ahead

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (refill_beat_valid && wr_way == 1'(w)) begin
                mem[w][{idx, refill_word}] <= refill_data;
            end else if (store_en && wr_way == 1'(w)) begin
                for (int b = 0; b < 4; b++) begin
                    if (wmask[b])
                        mem[w][{idx, req_word}][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            rd_q[w] <= mem[w][{idx, rd_word}];
        end
    end

    assign rdata = rd_q[rd_way];

endmodule

// File: hw/dcache_bus_port.sv
`timescale 1ns/1ps

module dcache_bus_port #(
    parameter int OFFSET_BITS = dcache_pkg::DEF_OFFSET_BITS
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start_wb,
    input  logic                    start_refill,
    input  dcache_pkg::addr_t       line_addr,
    input  dcache_pkg::addr_t       victim_line_addr,
    output logic [OFFSET_BITS-3:0]  rd_word,
    input  dcache_pkg::word_t       wb_data_in,
    output logic                    ar_valid,
    output dcache_pkg::mem_ar_t     ar,
    input  logic                    ar_ready,
    input  logic                    r_valid,
    input  dcache_pkg::mem_r_t      r,
    output logic                    aw_valid,
    output dcache_pkg::mem_aw_t     aw,
    input  logic                    aw_ready,
    output logic                    w_valid,
    output dcache_pkg::mem_w_t      w,
    input  logic                    w_ready,
    input  logic                    b_valid,
    output logic                    refill_beat_valid,
    output logic [OFFSET_BITS-3:0]  refill_word,
    output dcache_pkg::word_t       refill_data,
    output logic                    wb_done,
    output logic                    refill_done
);

    localparam int WORD_BITS = OFFSET_BITS - 2;
    localparam int NWORDS    = 1 << WORD_BITS;

    logic                 wb_act, rf_act;
    logic                 rd_vld;   // wb_data_in holds word fill_cnt
    logic [WORD_BITS:0]   rd_cnt, fill_cnt, w_cnt;
    logic [WORD_BITS-1:0] rf_cnt;
    dcache_pkg::word_t    line_buf [NWORDS];

    assign rd_word = rd_cnt[WORD_BITS-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_act   <= 1'b0;
            rf_act   <= 1'b0;
            rd_vld   <= 1'b0;
            ar_valid <= 1'b0;
            aw_valid <= 1'b0;
            rd_cnt   <= '0;
            fill_cnt <= '0;
            w_cnt    <= '0;
            rf_cnt   <= '0;
        end else begin
            rd_vld <= wb_act && !rd_cnt[WORD_BITS];
            if (start_wb) begin
                wb_act   <= 1'b1;
                aw_valid <= 1'b1;
                rd_cnt   <= '0;
                fill_cnt <= '0;
                w_cnt    <= '0;
            end else if (wb_act) begin
                if (!rd_cnt[WORD_BITS])
                    rd_cnt <= rd_cnt + 1'b1;
                if (rd_vld)
                    fill_cnt <= fill_cnt + 1'b1;
                if (w_valid && w_ready)
                    w_cnt <= w_cnt + 1'b1;
                if (aw_valid && aw_ready)
                    aw_valid <= 1'b0;
                if (b_valid)
                    wb_act <= 1'b0;
            end
            if (start_refill) begin
                rf_act   <= 1'b1;
                ar_valid <= 1'b1;
                rf_cnt   <= '0;
            end else if (rf_act) begin
                if (ar_valid && ar_ready)
                    ar_valid <= 1'b0;
                if (r_valid) begin
                    rf_cnt <= rf_cnt + 1'b1;
                    if (r.last)
                        rf_act <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_wb)
            aw <= '{addr: {victim_line_addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}},
                    len: 8'(NWORDS - 1)};
        if (start_refill)
            ar <= '{addr: {line_addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}},
                    len: 8'(NWORDS - 1)};
        if (rd_vld)
            line_buf[fill_cnt[WORD_BITS-1:0]] <= wb_data_in;
    end

    // a beat goes out once its word sits in the buffer
    assign w_valid = wb_act && (w_cnt < fill_cnt);
    assign w       = '{data: line_buf[w_cnt[WORD_BITS-1:0]], last: &w_cnt[WORD_BITS-1:0]};
    assign wb_done = wb_act && b_valid;

    assign refill_beat_valid = rf_act && r_valid;
    assign refill_word       = rf_cnt;
    assign refill_data       = r.data;
    assign refill_done       = rf_act && r_valid && r.last;

endmodule

// File: hw/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  dcache_pkg::cpu_req_t req,
    output logic                 req_ready,
    output logic                 rsp_valid,
    output dcache_pkg::cpu_rsp_t rsp,
    output dcache_pkg::cpu_req_t cur_req,
    input  dcache_pkg::word_t    rdata,
    input  logic                 hit,
    input  logic                 hit_way,
    input  logic                 victim_way,
    input  logic                 victim_dirty,
    output logic                 lookup_en,
    output logic                 tag_fill,
    output logic                 mark_access,
    output logic                 store_en,
    output logic                 wr_way,
    output logic                 rd_way,
    output logic                 rd_sel_wb,
    output logic                 start_wb,
    output logic                 start_refill,
    input  logic                 wb_done,
    input  logic                 refill_done
);

    dcache_pkg::ctrl_state_e state, state_nx;
    dcache_pkg::cpu_req_t    req_q;
    logic                    missed; // first lookup of this request missed

    assign req_ready = state == dcache_pkg::IDLE;
    assign rsp_valid = state == dcache_pkg::RESPOND;
    assign rsp       = '{rdata: rdata, hit: !missed};

    // arrays see the incoming request while idle so the read starts on acceptance
    assign cur_req = (state == dcache_pkg::IDLE) ? req : req_q;

    assign lookup_en   = (state == dcache_pkg::IDLE && req_valid) ||
                         state == dcache_pkg::LOOKUP;
    assign mark_access = state == dcache_pkg::LOOKUP && hit;
    assign store_en    = mark_access && req_q.op == dcache_pkg::OP_WRITE;
    assign tag_fill    = state == dcache_pkg::REFILL && refill_done;

    assign start_wb     = state == dcache_pkg::LOOKUP && !hit && victim_dirty;
    assign start_refill = (state == dcache_pkg::LOOKUP && !hit && !victim_dirty) ||
                          (state == dcache_pkg::WRITEBACK && wb_done);

    assign rd_sel_wb = state == dcache_pkg::WRITEBACK;
    assign rd_way    = rd_sel_wb ? victim_way : hit_way;
    assign wr_way    = (state == dcache_pkg::REFILL) ? victim_way : hit_way; // refill select

    always_comb begin
        state_nx = state;
        case (state)
            dcache_pkg::IDLE: begin
                if (req_valid)
                    state_nx = dcache_pkg::LOOKUP;
            end
            dcache_pkg::LOOKUP: begin
                if (hit)
                    state_nx = dcache_pkg::RESPOND;
                else if (victim_dirty)
                    state_nx = dcache_pkg::WRITEBACK;
                else
                    state_nx = dcache_pkg::REFILL;
            end
            dcache_pkg::WRITEBACK: begin
                if (wb_done)
                    state_nx = dcache_pkg::REFILL;
            end
            dcache_pkg::REFILL: begin
                if (refill_done)
                    state_nx = dcache_pkg::LOOKUP; // lookup again, hits now
            end
            dcache_pkg::RESPOND: state_nx = dcache_pkg::IDLE;
            default: state_nx = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= dcache_pkg::IDLE;
            missed <= 1'b0;
        end else begin
            state <= state_nx;
            if (req_valid && req_ready)
                missed <= 1'b0;
            else if (state == dcache_pkg::LOOKUP && !hit)
                missed <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready)
            req_q <= req;
    end

endmodule

// File: hw/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int INDEX_BITS  = dcache_pkg::DEF_INDEX_BITS,
    parameter int OFFSET_BITS = dcache_pkg::DEF_OFFSET_BITS
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  dcache_pkg::cpu_req_t req,
    output logic                 req_ready,
    output logic                 rsp_valid,
    output dcache_pkg::cpu_rsp_t rsp,
    output logic                 ar_valid,
    output dcache_pkg::mem_ar_t  ar,
    input  logic                 ar_ready,
    input  logic                 r_valid,
    input  dcache_pkg::mem_r_t   r,
    output logic                 aw_valid,
    output dcache_pkg::mem_aw_t  aw,
    input  logic                 aw_ready,
    output logic                 w_valid,
    output dcache_pkg::mem_w_t   w,
    input  logic                 w_ready,
    input  logic                 b_valid
);

    localparam int TAG_BITS  = 32 - INDEX_BITS - OFFSET_BITS;
    localparam int WORD_BITS = OFFSET_BITS - 2;

    dcache_pkg::cpu_req_t  cur_req;
    dcache_pkg::word_t     rdata;
    dcache_pkg::word_t     refill_data;
    logic                  lookup_en, tag_fill, mark_access, store_en;
    logic                  wr_way, rd_way, rd_sel_wb;
    logic                  hit, hit_way, victim_way, victim_dirty;
    logic                  start_wb, start_refill, wb_done, refill_done;
    logic                  refill_beat_valid;
    logic [TAG_BITS-1:0]   victim_tag;
    logic [WORD_BITS-1:0]  rd_word, refill_word;

    dcache_ctrl ctrl0 (
        .clk, .rst, .req_valid, .req, .req_ready, .rsp_valid, .rsp,
        .cur_req, .rdata, .hit, .hit_way, .victim_way, .victim_dirty,
        .lookup_en, .tag_fill, .mark_access, .store_en, .wr_way, .rd_way, .rd_sel_wb,
        .start_wb, .start_refill, .wb_done, .refill_done
    );

    dcache_tag_array #(.INDEX_BITS(INDEX_BITS), .OFFSET_BITS(OFFSET_BITS)) tags0 (
        .clk, .rst, .addr(cur_req.addr), .lookup_en, .tag_fill, .mark_access,
        .is_write(store_en), .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
    );

    dcache_data_array #(.INDEX_BITS(INDEX_BITS), .OFFSET_BITS(OFFSET_BITS)) data0 (
        .clk, .addr(cur_req.addr), .rd_addr(rd_word), .rd_sel_wb, .wr_way, .store_en,
        .wmask(cur_req.wmask), .wdata(cur_req.wdata), .refill_beat_valid, .refill_word,
        .refill_data, .rd_way, .rdata
    );

    dcache_bus_port #(.OFFSET_BITS(OFFSET_BITS)) bus0 (
        .clk, .rst, .start_wb, .start_refill, .line_addr(cur_req.addr),
        .victim_line_addr({victim_tag, cur_req.addr[OFFSET_BITS +: INDEX_BITS],
                           {OFFSET_BITS{1'b0}}}),
        .rd_word, .wb_data_in(rdata),
        .ar_valid, .ar, .ar_ready, .r_valid, .r, .aw_valid, .aw, .aw_ready,
        .w_valid, .w, .w_ready, .b_valid,
        .refill_beat_valid, .refill_word, .refill_data, .wb_done, .refill_done
    );

endmodule

// File: tb/mem_model.sv
`timescale 1ns/1ps

module mem_model (
    input  logic                clk,
    input  logic                bp_en, // random ready back-pressure
    input  logic                ar_valid,
    input  dcache_pkg::mem_ar_t ar,
    output logic                ar_ready,
    output logic                r_valid,
    output dcache_pkg::mem_r_t  r,
    input  logic                aw_valid,
    input  dcache_pkg::mem_aw_t aw,
    output logic                aw_ready,
    input  logic                w_valid,
    input  dcache_pkg::mem_w_t  w,
    output logic                w_ready,
    output logic                b_valid
);

    dcache_pkg::word_t   mem [dcache_pkg::addr_t]; // sparse, pattern where unwritten
    dcache_pkg::word_t   wb_words [16];            // beats of the last write burst
    dcache_pkg::addr_t   rd_addr, wr_addr, last_aw_addr;
    logic [7:0]          last_aw_len;
    dcache_pkg::mem_ar_t ar_q;
    dcache_pkg::mem_aw_t aw_q;
    dcache_pkg::mem_w_t  w_q;
    int                  seed;
    int                  rd_cnt, rd_len, wr_cnt;
    int                  ar_count, aw_count, r_beats;
    logic                rd_act, wr_act, b_pend;
    logic                ar_hs, aw_hs, w_hs, r_hs;

    function automatic dcache_pkg::word_t peek(input dcache_pkg::addr_t a);
        dcache_pkg::addr_t wa;
        wa = {a[31:2], 2'b00};
        if (mem.exists(wa))
            return mem[wa];
        return wa ^ 32'h5a5a0000;
    endfunction

    function automatic logic pick();
        if (!bp_en)
            return 1'b1;
        return ($random(seed) & 3) != 0; // ready about 3 times in 4
    endfunction

    initial begin
        seed = 32'he724b8f3;
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r = '0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        rd_act = 1'b0;
        wr_act = 1'b0;
        b_pend = 1'b0;
        rd_addr = '0;
        wr_addr = '0;
        last_aw_addr = '0;
        last_aw_len = '0;
        rd_cnt = 0;
        rd_len = 0;
        wr_cnt = 0;
        ar_count = 0;
        aw_count = 0;
        r_beats = 0;
        forever begin
            @(negedge clk); // handshakes that the next edge will take
            ar_hs = ar_valid && ar_ready;
            aw_hs = aw_valid && aw_ready;
            w_hs  = w_valid && w_ready;
            r_hs  = r_valid;
            ar_q  = ar;
            aw_q  = aw;
            w_q   = w;
            @(posedge clk);
            #1;
            if (r_hs) begin
                r_beats++;
                rd_cnt++;
                if (rd_cnt > rd_len)
                    rd_act = 1'b0;
            end
            if (ar_hs) begin
                rd_act = 1'b1;
                rd_addr = ar_q.addr;
                rd_len = int'(ar_q.len);
                rd_cnt = 0;
                ar_count++;
            end
            if (aw_hs) begin
                wr_act = 1'b1;
                wr_addr = aw_q.addr;
                last_aw_addr = aw_q.addr;
                last_aw_len = aw_q.len;
                wr_cnt = 0;
                aw_count++;
            end
            if (w_hs) begin
                mem[wr_addr + 32'(4 * wr_cnt)] = w_q.data;
                wb_words[wr_cnt[3:0]] = w_q.data;
                wr_cnt++;
                if (w_q.last) begin
                    wr_act = 1'b0;
                    b_pend = 1'b1;
                end
            end
            b_valid = b_pend; // single cycle response
            b_pend = 1'b0;
            ar_ready = pick();
            aw_ready = pick();
            w_ready = wr_act && pick();
            r_valid = rd_act && pick();
            r = '{data: peek(rd_addr + 32'(4 * rd_cnt)), last: rd_cnt == rd_len};
        end
    end

endmodule

// File: tb/dcache_assert.sv
`timescale 1ns/1ps

module dcache_assert (
    input logic                clk,
    input logic                rst,
    input logic                req_valid,
    input logic                req_ready,
    input logic                rsp_valid,
    input logic                ar_valid,
    input logic                ar_ready,
    input dcache_pkg::mem_ar_t ar,
    input logic                aw_valid,
    input logic                aw_ready,
    input dcache_pkg::mem_aw_t aw,
    input logic                w_valid,
    input logic                w_ready,
    input dcache_pkg::mem_w_t  w
);

    logic in_flight; // accepted, not answered yet

    always_ff @(posedge clk) begin
        if (rst)
            in_flight <= 1'b0;
        else if (rsp_valid)
            in_flight <= 1'b0;
        else if (req_valid && req_ready)
            in_flight <= 1'b1;
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar)) else $error("ar dropped before ready");
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw)) else $error("aw dropped before ready");
    w_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w)) else $error("w dropped before ready");

    // a second response cycle finds no open request
    rsp_once: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> in_flight) else $error("response without an open request");
    busy_ready: assert property (@(posedge clk) disable iff (rst)
        in_flight |-> !req_ready) else $error("req_ready high with a request in flight");

endmodule

bind dcache_top dcache_assert assert0 (
    .clk, .rst, .req_valid, .req_ready, .rsp_valid, .ar_valid, .ar_ready, .ar,
    .aw_valid, .aw_ready, .aw, .w_valid, .w_ready, .w
);

// File: tb/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    localparam int TMO   = 2000; // cycles per wait
    localparam int NROWS = 12;

    typedef struct {
        dcache_pkg::cpu_op_e op;
        dcache_pkg::addr_t   addr;
        dcache_pkg::wmask_t  wmask;
        dcache_pkg::word_t   wdata;
        dcache_pkg::word_t   exp_rdata;
        int                  exp_hit; // 1 hit, 0 miss
        int                  n_ar;
        int                  n_aw;
        dcache_pkg::addr_t   aw_addr;
        int                  wb_idx;  // beat of the writeback to check, -1 none
    } row_t;

    logic                 clk, rst, req_valid, req_ready, rsp_valid, bp_en;
    dcache_pkg::cpu_req_t req;
    dcache_pkg::cpu_rsp_t rsp;
    logic                 ar_valid, ar_ready, r_valid, aw_valid, aw_ready;
    logic                 w_valid, w_ready, b_valid;
    dcache_pkg::mem_ar_t  ar;
    dcache_pkg::mem_r_t   r;
    dcache_pkg::mem_aw_t  aw;
    dcache_pkg::mem_w_t   w;

    row_t                 tbl [NROWS];
    dcache_pkg::word_t    sb [dcache_pkg::addr_t]; // expected memory image
    dcache_pkg::cpu_rsp_t got;
    dcache_pkg::addr_t    ra;
    dcache_pkg::word_t    rd_exp, wd;
    dcache_pkg::wmask_t   wm;
    int                   seed, lat, ar0, aw0, rb0, errs, fails, passed, bad;
    bit                   ok, abort;

    dcache_top dut0 (
        .clk, .rst, .req_valid, .req, .req_ready, .rsp_valid, .rsp,
        .ar_valid, .ar, .ar_ready, .r_valid, .r, .aw_valid, .aw, .aw_ready,
        .w_valid, .w, .w_ready, .b_valid
    );

    mem_model mem0 (
        .clk, .bp_en, .ar_valid, .ar, .ar_ready, .r_valid, .r, .aw_valid, .aw, .aw_ready,
        .w_valid, .w, .w_ready, .b_valid
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic dcache_pkg::word_t sb_read(input dcache_pkg::addr_t a);
        if (sb.exists(a))
            return sb[a];
        return a ^ 32'h5a5a0000;
    endfunction

    function automatic void sb_write(input dcache_pkg::addr_t a, input dcache_pkg::wmask_t m,
                                     input dcache_pkg::word_t d);
        dcache_pkg::word_t v;
        v = sb_read(a);
        for (int b = 0; b < 4; b++) begin
            if (m[b])
                v[8*b +: 8] = d[8*b +: 8];
        end
        sb[a] = v;
    endfunction

    // one request through the CPU port; lat counts edges from accept to response
    task automatic send_req(input dcache_pkg::cpu_op_e op, input dcache_pkg::addr_t a,
                            input dcache_pkg::wmask_t m, input dcache_pkg::word_t d,
                            output dcache_pkg::cpu_rsp_t rs, output int lt, output bit good);
        int n;
        good = 1'b0;
        lt = 1;
        req_valid = 1'b1;
        req = '{op: op, addr: a, wmask: m, wdata: d};
        for (n = 0; n < TMO; n++) begin
            @(negedge clk);
            if (req_ready)
                break;
        end
        if (n == TMO) begin
            req_valid = 1'b0;
            return;
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        for (n = 0; n < TMO; n++) begin
            @(negedge clk);
            if (rsp_valid) begin
                rs = rsp;
                good = 1'b1;
                break;
            end
            lt++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic add_row(input int i, input dcache_pkg::cpu_op_e op, input dcache_pkg::addr_t a,
                           input dcache_pkg::wmask_t m, input dcache_pkg::word_t d,
                           input dcache_pkg::word_t e, input int h, input int nar,
                           input int naw, input dcache_pkg::addr_t awa, input int wbi);
        tbl[i] = '{op, a, m, d, e, h, nar, naw, awa, wbi};
    endtask

    initial begin
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        bp_en = 1'b0;
        seed = 32'he724b8f3;
        errs = 0;
        fails = 0;
        passed = 0;
        abort = 1'b0;

        add_row(0, dcache_pkg::OP_READ, 32'h1040, 4'hf, 0, 32'h5a5a1040, 0, 1, 0, 0, -1);
        add_row(1, dcache_pkg::OP_READ, 32'h1044, 4'hf, 0, 32'h5a5a1044, 1, 0, 0, 0, -1);
        add_row(2, dcache_pkg::OP_WRITE, 32'h1048, 4'h3, 32'hdeadbeef, 0, 1, 0, 0, 0, -1);
        add_row(3, dcache_pkg::OP_READ, 32'h1048, 4'hf, 0, 32'h5a5abeef, 1, 0, 0, 0, -1);
        add_row(4, dcache_pkg::OP_READ, 32'h2040, 4'hf, 0, 32'h5a5a2040, 0, 1, 0, 0, -1);
        // dirty line 0x1040 gets evicted here, stored word in beat 2
        add_row(5, dcache_pkg::OP_READ, 32'h3040, 4'hf, 0, 32'h5a5a3040, 0, 1, 1, 32'h1040, 2);
        add_row(6, dcache_pkg::OP_READ, 32'h1048, 4'hf, 0, 32'h5a5abeef, 0, 1, 0, 0, -1);
        add_row(7, dcache_pkg::OP_READ, 32'h1080, 4'hf, 0, 32'h5a5a1080, 0, 1, 0, 0, -1);
        add_row(8, dcache_pkg::OP_READ, 32'h2080, 4'hf, 0, 32'h5a5a2080, 0, 1, 0, 0, -1);
        add_row(9, dcache_pkg::OP_READ, 32'h1084, 4'hf, 0, 32'h5a5a1084, 1, 0, 0, 0, -1);
        add_row(10, dcache_pkg::OP_READ, 32'h3080, 4'hf, 0, 32'h5a5a3080, 0, 1, 0, 0, -1);
        add_row(11, dcache_pkg::OP_READ, 32'h1088, 4'hf, 0, 32'h5a5a1088, 1, 0, 0, 0, -1);

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;

        for (int i = 0; i < NROWS; i++) begin
            ar0 = mem0.ar_count;
            aw0 = mem0.aw_count;
            rb0 = mem0.r_beats;
            bad = errs;
            send_req(tbl[i].op, tbl[i].addr, tbl[i].wmask, tbl[i].wdata, got, lat, ok);
            if (!ok) begin
                $display("test %0d timed out waiting for the cache", i);
                errs++;
                fails++;
                abort = 1'b1;
                break;
            end
            if (tbl[i].op == dcache_pkg::OP_WRITE)
                sb_write(tbl[i].addr, tbl[i].wmask, tbl[i].wdata);
            if (tbl[i].op == dcache_pkg::OP_READ && got.rdata != tbl[i].exp_rdata) begin
                $display("MISMATCH %0t: test %0d rdata %h expected %h",
                         $time, i, got.rdata, tbl[i].exp_rdata);
                errs++;
            end
            if (int'(got.hit) != tbl[i].exp_hit) begin
                $display("MISMATCH %0t: test %0d hit %0d expected %0d",
                         $time, i, got.hit, tbl[i].exp_hit);
                errs++;
            end
            if (tbl[i].exp_hit == 1 && lat != 2) begin
                $display("MISMATCH %0t: test %0d hit latency %0d expected 2", $time, i, lat);
                errs++;
            end
            if (mem0.ar_count - ar0 != tbl[i].n_ar || mem0.aw_count - aw0 != tbl[i].n_aw) begin
                $display("MISMATCH %0t: test %0d bursts ar %0d aw %0d expected ar %0d aw %0d",
                         $time, i, mem0.ar_count - ar0, mem0.aw_count - aw0,
                         tbl[i].n_ar, tbl[i].n_aw);
                errs++;
            end
            if (mem0.r_beats - rb0 != 16 * tbl[i].n_ar) begin
                $display("MISMATCH %0t: test %0d got %0d r beats", $time, i, mem0.r_beats - rb0);
                errs++;
            end
            if (tbl[i].n_aw > 0 &&
                (mem0.last_aw_addr != tbl[i].aw_addr || mem0.last_aw_len != 8'd15)) begin
                $display("MISMATCH %0t: test %0d aw addr %h len %0d expected %h len 15",
                         $time, i, mem0.last_aw_addr, mem0.last_aw_len, tbl[i].aw_addr);
                errs++;
            end
            if (tbl[i].wb_idx >= 0 &&
                mem0.wb_words[tbl[i].wb_idx] != sb_read(tbl[i].aw_addr + 32'(4 * tbl[i].wb_idx)))
            begin
                $display("MISMATCH %0t: test %0d writeback beat %0d is %h", $time, i,
                         tbl[i].wb_idx, mem0.wb_words[tbl[i].wb_idx]);
                errs++;
            end
            if (errs == bad) begin
                passed++;
                $display("test %0d addr %h ok", i, tbl[i].addr);
            end else begin
                fails++;
                $display("test %0d addr %h FAILED", i, tbl[i].addr);
            end
        end

        // random traffic in set 3 under memory back-pressure
        if (!abort) begin
            bp_en = 1'b1;
            bad = errs;
            for (int k = 0; k < 60; k++) begin
                ra = 32'h00c0 | (32'($random(seed) & 3) << 12) | (32'($random(seed) & 15) << 2);
                if ($random(seed) & 1) begin
                    wm = 4'($random(seed));
                    wd = $random(seed);
                    send_req(dcache_pkg::OP_WRITE, ra, wm, wd, got, lat, ok);
                    if (ok)
                        sb_write(ra, wm, wd);
                end else begin
                    rd_exp = sb_read(ra);
                    send_req(dcache_pkg::OP_READ, ra, 4'hf, 0, got, lat, ok);
                    if (ok && got.rdata != rd_exp) begin
                        $display("MISMATCH %0t: random op %0d addr %h rdata %h expected %h",
                                 $time, k, ra, got.rdata, rd_exp);
                        errs++;
                    end
                end
                if (!ok) begin
                    $display("random op %0d timed out waiting for the cache", k);
                    errs++;
                    break;
                end
            end
            if (errs == bad) begin
                passed++;
                $display("test random back-pressure ok");
            end else begin
                fails++;
                $display("test random back-pressure FAILED");
            end
        end

        $display("tests passed %0d failed %0d errors %0d", passed, fails, errs);
        if (errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
hw/dcache_pkg.sv
hw/dcache_tag_array.sv
hw/dcache_data_array.sv
hw/dcache_bus_port.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
tb/mem_model.sv
tb/dcache_assert.sv
tb/tb_dcache.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f filelist.f
	@out=$$(./obj_dir/Vtb_dcache); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir
